/* testbench/testdata_main.txt */
# kind addr data expected. R: data = select mask {obj,pal,char,vram,ram,rom}, expected = rdata
# W: data = wdata, expected = select mask. S: addr = input number. V, M: data = pulses, max wait
R 000100 01 1080
R 04000a 01 1005
R 060246 02 2123
R 200a00 04 2500
R 210080 08 3040
R 400ffe 10 47ff
R 600010 20 5008
R a00000 00 ffff
R e00004 00 ffff
R 800012 00 ffff
W 000100 1234 00
W 060010 abcd 02
M 0 8 0
R 000200 01 1100
R 06fffe 02 2fff
R 201234 04 291a
R 21fffe 08 3fff
R 000202 01 1101
M 0 0 0
R 800004 00 ff21
R 800002 00 ffff
W 800002 0055 00
R 800002 00 ff55
W 800004 00c0 00
R 800004 00 ffc0
W 800004 0061 00
R 800004 00 ff61
R 800070 00 ffff
W 800070 0000 00
W 800004 0021 00
S 3 2 0
S 1 7f 0
S 2 2 0
S 4 0 0
S 5 1 0
R 800010 00 ffa3
S 1 ff 0
S 3 1 0
S 2 3 0
S 4 1 0
S 5 0 0
R 800010 00 ff5d
S 6 3c 0
S 7 a5 0
R 800014 00 ff3c
R 800016 00 ffa5
S 0 0 0
S 8 1234 0
S 9 d500 0
W 800030 0000 00
S 8 0 0
R 800030 00 ffb4
W 800004 0025 00
R 800030 00 ff54
W 800004 0029 00
R 800030 00 ff00
S 9 3a00 0
W 800030 0000 00
R 800030 00 ff74
W 800004 0025 00
R 800030 00 ff00
S 0 3 0
S 1 de 0
R 800030 00 ffff
W 800004 0029 00
R 800030 00 ff00
W 800004 0021 00
R 800030 00 ffe0
S 1 bd 0
R 800030 00 ff20
W 800004 0029 00
R 800030 00 ffff
S 1 ff 0
W 800004 0021 00
R 800030 00 ff80
S 0 0 0
R 800000 00 ff17
W 800004 002d 00
R 800030 00 ff80
W 800002 0010 00
V 0 3 0
R 800030 00 ffb0
V 0 4 0
R 800030 00 ffe0
R 800000 00 ff0f
W 800002 00c0 00
V 0 2 0
R 800030 00 ff60
V 0 2 0
R 800030 00 ff20
R 800000 00 ff27

/* list.f */
rtl/outrun_pkg.sv
rtl/ppi_8255.sv
rtl/motor_model.sv
rtl/cab_io.sv
rtl/main_bus.sv
rtl/main_board.sv
testbench/tb_main_board.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_main_board -f list.f

out=$(./obj_dir/Vtb_main_board)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1

/* testbench/tb_main_board.sv */
`timescale 1ns/100ps

module tb_main_board import outrun_pkg::*; ();

    localparam int TIMEOUT = 200;   // Cycles allowed for one ack

    logic                  clk;
    logic                  rst;
    logic                  bus_req;
    logic [ADDR_W:1]       addr;
    logic                  rnw;
    logic [1:0]            dsn;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     rom_data;
    logic                  rom_ok = 1'b0;
    logic [DATA_W-1:0]     ram_data;
    logic                  ram_ok = 1'b0;
    logic [DATA_W-1:0]     char_dout;
    logic [DATA_W-1:0]     pal_dout;
    logic [DATA_W-1:0]     obj_dout;
    logic                  vint;
    logic [3:0]            ctrl_type;
    logic [7:0]            joystick1;
    logic [1:0]            start_button;
    logic [1:0]            coin_input;
    logic                  service;
    logic                  dip_test;
    logic [7:0]            dipsw_a;
    logic [7:0]            dipsw_b;
    logic [15:0]           joyana1;
    logic [15:0]           joyana1b;
    logic                  ack;
    logic [DATA_W-1:0]     rdata;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic                  rom_cs;
    logic                  ram_cs;
    logic                  vram_cs;
    logic                  char_cs;
    logic                  pal_cs;
    logic                  obj_cs;
    logic                  video_en;
    logic                  snd_rstb;
    logic [1:0]            obj_cfg;
    logic                  obj_toggle;

    int         wait_left = 0;
    int         next_wait = 0;
    int         max_wait = 0;
    int         errors = 0;
    int         tests = 0;
    int         failed_tests = 0;
    logic       timed_out = 1'b0;
    logic [7:0] portc_model = 8'h21;   // Port C as the game last wrote it

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Memory side, each source tagged in the top nibble
    assign rom_data  = {4'h1, mem_addr[11:0]};
    assign ram_data  = {4'h2, mem_addr[11:0]};
    assign char_dout = {4'h3, mem_addr[11:0]};
    assign pal_dout  = {4'h4, mem_addr[11:0]};
    assign obj_dout  = {4'h5, mem_addr[11:0]};

    always @(posedge clk) begin
        if (!(rom_cs || ram_cs || vram_cs)) begin
            wait_left <= next_wait;       // Loaded while idle
            rom_ok    <= 1'b0;
            ram_ok    <= 1'b0;
        end else if (wait_left == 0) begin
            rom_ok <= rom_cs;
            ram_ok <= ram_cs || vram_cs;
        end else begin
            wait_left <= wait_left - 1;
        end
    end

    main_board #(
        .MOTOR_SHIFT (8)
    ) u_main_board (
        .clk          (clk),
        .rst          (rst),
        .bus_req      (bus_req),
        .addr         (addr),
        .rnw          (rnw),
        .dsn          (dsn),
        .wdata        (wdata),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .ram_data     (ram_data),
        .ram_ok       (ram_ok),
        .char_dout    (char_dout),
        .pal_dout     (pal_dout),
        .obj_dout     (obj_dout),
        .vint         (vint),
        .ctrl_type    (ctrl_type),
        .joystick1    (joystick1),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .joyana1      (joyana1),
        .joyana1b     (joyana1b),
        .ack          (ack),
        .rdata        (rdata),
        .mem_addr     (mem_addr),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .vram_cs      (vram_cs),
        .char_cs      (char_cs),
        .pal_cs       (pal_cs),
        .obj_cs       (obj_cs),
        .video_en     (video_en),
        .snd_rstb     (snd_rstb),
        .obj_cfg      (obj_cfg),
        .obj_toggle   (obj_toggle)
    );

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, got_val);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic check_port_c_pins();
        if (video_en !== portc_model[5])
            report_mismatch("video_en", {31'd0, portc_model[5]}, {31'd0, video_en});
        if (snd_rstb !== portc_model[0])
            report_mismatch("snd_rstb", {31'd0, portc_model[0]}, {31'd0, snd_rstb});
        if (obj_cfg !== portc_model[7:6])
            report_mismatch("obj_cfg", {30'd0, portc_model[7:6]}, {30'd0, obj_cfg});
    endtask

    task automatic set_input(input logic [3:0] id, input logic [15:0] val);
        @(posedge clk);
        case (id)
            4'd0: ctrl_type    <= val[3:0];
            4'd1: joystick1    <= val[7:0];
            4'd2: start_button <= val[1:0];
            4'd3: coin_input   <= val[1:0];
            4'd4: service      <= val[0];
            4'd5: dip_test     <= val[0];
            4'd6: dipsw_a      <= val[7:0];
            4'd7: dipsw_b      <= val[7:0];
            4'd8: joyana1      <= val;
            4'd9: joyana1b     <= val;
            default: report_failure("unknown cabinet input number in data file");
        endcase
    endtask

    task automatic pulse_vint(input int count);
        repeat (count) begin
            @(posedge clk);
            vint <= 1'b1;
            repeat (2) @(posedge clk);
            vint <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    // One bus cycle with the full handshake, checked against the expected select and data
    task automatic bus_access(input logic is_read, input logic [23:0] byte_addr,
                              input logic [15:0] wr_data, input logic [5:0] exp_cs,
                              input logic [15:0] exp_data);
        int         edges;
        int         ok_edge;
        int         pulses;
        int         exp_pulses;
        int         errs_before;
        logic       mem_cycle;
        logic [5:0] cs_seen;
        string      op_name;
        errs_before = errors;
        edges       = 0;
        ok_edge     = -1;
        pulses      = 0;
        exp_pulses  = (byte_addr[23:21] == 3'd4 && byte_addr[6:4] == 3'd7) ? 1 : 0;
        mem_cycle   = exp_cs[0] || exp_cs[1] || exp_cs[2];
        next_wait   = (max_wait > 0) ? $urandom % (max_wait + 1) : 0;
        if (is_read) op_name = "read";
        else op_name = "write";

        @(posedge clk);
        bus_req <= 1'b1;
        addr    <= byte_addr[23:1];
        rnw     <= is_read;
        dsn     <= 2'b00;
        wdata   <= wr_data;
        @(negedge clk);
        while (!ack && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (obj_toggle) pulses++;
            if (obj_toggle && !ack) report_failure("obj_toggle high outside the ack cycle");
            if (ok_edge < 0 && ((rom_cs && rom_ok) || ((ram_cs || vram_cs) && ram_ok)))
                ok_edge = edges;
        end

        if (!ack) begin
            $display("Timeout: no ack within %0d cycles for the %s at %h",
                     TIMEOUT, op_name, byte_addr);
            timed_out = 1'b1;
            errors++;
        end else begin
            cs_seen = {obj_cs, pal_cs, char_cs, vram_cs, ram_cs, rom_cs};
            if (cs_seen !== exp_cs)
                report_mismatch("chip selects", {26'd0, exp_cs}, {26'd0, cs_seen});
            // Memory address is the word address without the region bits
            if (mem_addr !== byte_addr[19:1])
                report_mismatch("mem_addr", {13'd0, byte_addr[19:1]}, {13'd0, mem_addr});
            if (is_read && rdata !== exp_data)
                report_mismatch("rdata", {16'd0, exp_data}, {16'd0, rdata});
            if (mem_cycle && ok_edge < 0)
                report_failure("ack came without the memory reporting ok");
            else if (mem_cycle && edges != ok_edge + 1)
                report_mismatch("ack cycle", ok_edge + 1, edges);
            else if (!mem_cycle && edges != 2)
                report_mismatch("ack cycle", 2, edges);

            @(posedge clk);
            bus_req <= 1'b0;
            rnw     <= 1'b1;
            dsn     <= 2'b11;
            @(negedge clk);
            if (obj_toggle) pulses++;
            if (pulses != exp_pulses) report_mismatch("obj_toggle pulses", exp_pulses, pulses);

            // Port C register sits at I/O offset 4
            if (!is_read && byte_addr[23:21] == 3'd4 && byte_addr[6:4] == 3'd0
                    && byte_addr[2:1] == 2'd2)
                portc_model = wr_data[7:0];
            check_port_c_pins();
        end

        tests++;
        if (errors == errs_before) begin
            $display("%s %h: ok", op_name, byte_addr);
        end else begin
            failed_tests++;
            $display("%s %h: failed", op_name, byte_addr);
        end
    endtask

    initial begin
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [31:0]      f_addr;
        logic [31:0]      f_data;
        logic [31:0]      f_exp;
        logic [8*120-1:0] line;
        void'($urandom(32'h4465));

        rst          = 1'b1;
        bus_req      = 1'b0;
        addr         = '0;
        rnw          = 1'b1;
        dsn          = 2'b11;
        wdata        = '0;
        vint         = 1'b0;
        ctrl_type    = 4'd0;
        joystick1    = 8'hff;       // Active low switches released
        start_button = 2'b11;
        coin_input   = 2'b11;
        service      = 1'b1;
        dip_test     = 1'b1;
        dipsw_a      = 8'hff;
        dipsw_b      = 8'hff;
        joyana1      = 16'h0000;
        joyana1b     = 16'h0000;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_port_c_pins();

        fd = $fopen("testbench/testdata_main.txt", "r");
        if (fd == 0) begin
            report_failure("could not open testbench/testdata_main.txt");
        end else begin
            while (!timed_out && $fscanf(fd, " %s", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h", f_addr, f_data, f_exp);
                    if (code != 3) report_failure("malformed line in data file");
                    case (kind)
                        "R": bus_access(1'b1, f_addr[23:0], 16'h0000, f_data[5:0], f_exp[15:0]);
                        "W": bus_access(1'b0, f_addr[23:0], f_data[15:0], f_exp[5:0], 16'h0000);
                        "S": set_input(f_addr[3:0], f_data[15:0]);
                        "V": pulse_vint(int'(f_data));
                        "M": max_wait = int'(f_data);
                        default: report_failure("unknown operation in data file");
                    endcase
                end
            end
            $fclose(fd);
        end
        if (tests == 0) report_failure("no bus accesses were run");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* rtl/main_board.sv */
`timescale 1ns/100ps

module main_board import outrun_pkg::*; #(
    parameter int MOTOR_SHIFT = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_req,
    input  logic [ADDR_W:1]       addr,
    input  logic                  rnw,
    input  logic [1:0]            dsn,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W-1:0]     rom_data,
    input  logic                  rom_ok,
    input  logic [DATA_W-1:0]     ram_data,
    input  logic                  ram_ok,
    input  logic [DATA_W-1:0]     char_dout,
    input  logic [DATA_W-1:0]     pal_dout,
    input  logic [DATA_W-1:0]     obj_dout,
    input  logic                  vint,
    input  logic [3:0]            ctrl_type,
    input  logic [7:0]            joystick1,
    input  logic [1:0]            start_button,
    input  logic [1:0]            coin_input,
    input  logic                  service,
    input  logic                  dip_test,
    input  logic [7:0]            dipsw_a,
    input  logic [7:0]            dipsw_b,
    input  logic [15:0]           joyana1,
    input  logic [15:0]           joyana1b,
    output logic                  ack,
    output logic [DATA_W-1:0]     rdata,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic                  rom_cs,
    output logic                  ram_cs,
    output logic                  vram_cs,
    output logic                  char_cs,
    output logic                  pal_cs,
    output logic                  obj_cs,
    output logic                  video_en,
    output logic                  snd_rstb,
    output logic [1:0]            obj_cfg,
    output logic                  obj_toggle
);

    logic       io_cs;
    logic [7:0] io_dout;

    main_bus u_bus (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .addr      (addr),
        .rnw       (rnw),
        .dsn       (dsn),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .io_dout   (io_dout),
        .ack       (ack),
        .rdata     (rdata),
        .mem_addr  (mem_addr),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .obj_cs    (obj_cs),
        .io_cs     (io_cs)
    );

    cab_io #(
        .MOTOR_SHIFT (MOTOR_SHIFT)
    ) u_cab (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .ack          (ack),
        .addr         (addr),
        .rnw          (rnw),
        .dsn          (dsn),
        .wdata        (wdata),
        .vint         (vint),
        .ctrl_type    (ctrl_type),
        .joystick1    (joystick1),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .joyana1      (joyana1),
        .joyana1b     (joyana1b),
        .io_dout      (io_dout),
        .video_en     (video_en),
        .snd_rstb     (snd_rstb),
        .obj_cfg      (obj_cfg),
        .obj_toggle   (obj_toggle)
    );

endmodule

/* rtl/main_bus.sv */
`timescale 1ns/100ps

module main_bus import outrun_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_req,
    input  logic [ADDR_W:1]       addr,
    input  logic                  rnw,
    input  logic [1:0]            dsn,
    input  logic [DATA_W-1:0]     rom_data,
    input  logic                  rom_ok,
    input  logic [DATA_W-1:0]     ram_data,   // RAM and VRAM share this bus
    input  logic                  ram_ok,
    input  logic [DATA_W-1:0]     char_dout,
    input  logic [DATA_W-1:0]     pal_dout,
    input  logic [DATA_W-1:0]     obj_dout,
    input  logic [7:0]            io_dout,
    output logic                  ack,
    output logic [DATA_W-1:0]     rdata,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic                  rom_cs,
    output logic                  ram_cs,
    output logic                  vram_cs,
    output logic                  char_cs,
    output logic                  pal_cs,
    output logic                  obj_cs,
    output logic                  io_cs
);

    typedef enum logic [1:0] {
        st_idle,
        st_select,
        st_done
    } bus_state_e;

    bus_state_e        state;
    region_e           region;
    logic              strobe;
    logic              ram_page;
    logic              sel_ok;
    logic [DATA_W-1:0] read_mux;

    assign mem_addr = addr[MEM_ADDR_W:1];
    assign strobe   = ~&dsn;             // At least one byte lane active
    assign ram_page = addr[18:17] == RAM_PAGE;
    assign region   = addr[ADDR_W:ADDR_W-2] <= 3'd4 ? region_e'(addr[ADDR_W:ADDR_W-2])
                                                     : reg_none;

    // Only the external memories can stall the cycle
    assign sel_ok = rom_cs             ? rom_ok :
                    (ram_cs | vram_cs) ? ram_ok : 1'b1;

    always_comb begin
        if (ram_cs || vram_cs) begin
            read_mux = ram_data;
        end else if (rom_cs) begin
            read_mux = rom_data;
        end else if (char_cs) begin
            read_mux = char_dout;
        end else if (pal_cs) begin
            read_mux = pal_dout;
        end else if (obj_cs) begin
            read_mux = obj_dout;
        end else if (io_cs) begin
            read_mux = {8'hff, io_dout};
        end else begin
            read_mux = 16'hffff;         // Unmapped
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            ack     <= 1'b0;
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            vram_cs <= 1'b0;
            char_cs <= 1'b0;
            pal_cs  <= 1'b0;
            obj_cs  <= 1'b0;
            io_cs   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (bus_req) begin
                        rom_cs  <= region == reg_mem && !ram_page && rnw;
                        ram_cs  <= region == reg_mem &&  ram_page && strobe;
                        char_cs <= region == reg_scr &&  addr[16];
                        vram_cs <= region == reg_scr && !addr[16] && strobe;
                        pal_cs  <= region == reg_pal;
                        obj_cs  <= region == reg_obj;
                        io_cs   <= region == reg_io;
                        state   <= st_select;
                    end
                end
                st_select: begin
                    if (sel_ok) begin
                        ack   <= 1'b1;
                        state <= st_done;
                    end
                end
                st_done: begin
                    // Selects stay up through the ack cycle for the I/O strobes
                    rom_cs  <= 1'b0;
                    ram_cs  <= 1'b0;
                    vram_cs <= 1'b0;
                    char_cs <= 1'b0;
                    pal_cs  <= 1'b0;
                    obj_cs  <= 1'b0;
                    io_cs   <= 1'b0;
                    if (!bus_req) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_select && sel_ok) rdata <= read_mux;
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, obj_cs, io_cs}));

    assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

/* rtl/cab_io.sv */
`timescale 1ns/100ps

module cab_io import outrun_pkg::*; #(
    parameter int MOTOR_SHIFT = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              io_cs,
    input  logic              ack,
    input  logic [ADDR_W:1]   addr,
    input  logic              rnw,
    input  logic [1:0]        dsn,
    input  logic [DATA_W-1:0] wdata,
    input  logic              vint,
    input  logic [3:0]        ctrl_type,
    input  logic [7:0]        joystick1,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic              dip_test,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic [15:0]       joyana1,
    input  logic [15:0]       joyana1b,
    output logic [7:0]        io_dout,
    output logic              video_en,
    output logic              snd_rstb,
    output logic [1:0]        obj_cfg,
    output logic              obj_toggle
);

    io_sel_e     io_sel;
    adc_ch_e     adc_ch;
    ctrl_type_e  ctrl;
    logic [15:0] ana1;
    logic [15:0] ana1b;
    logic [15:0] motor_pos;
    logic [2:0]  motor_lim;
    logic [7:0]  ppi_dout;
    logic [7:0]  portb;
    logic [7:0]  portc;
    logic [7:0]  switches;
    logic [7:0]  adc_dout;
    logic        ppi_sel;
    logic        ppi_wr;
    logic        adc_wr;

    always_comb begin
        case (addr[6:4])
            3'd0:    io_sel = sel_ppi;
            3'd1:    io_sel = sel_inputs;
            3'd3:    io_sel = sel_adc;
            3'd7:    io_sel = sel_obj_toggle;
            default: io_sel = sel_none;
        endcase
    end

    assign adc_ch = adc_ch_e'(portc[4:2]);
    assign ctrl   = ctrl_type_e'(ctrl_type);

    assign ppi_sel    = io_cs && io_sel == sel_ppi;
    assign ppi_wr     = ack && !rnw && !dsn[0];     // Low byte lane only
    assign adc_wr     = io_cs && ack && !rnw && io_sel == sel_adc;
    assign obj_toggle = io_cs && ack && io_sel == sel_obj_toggle;

    assign obj_cfg  = portc[7:6];  // Bit 1 to object engine, bit 0 to colour mixer
    assign video_en = portc[5];
    assign snd_rstb = portc[0];

    // Analog inputs are sampled when the game starts a conversion
    always_ff @(posedge clk) begin
        if (adc_wr) begin
            ana1  <= joyana1;
            ana1b <= joyana1b;
        end
    end

    always_comb begin
        case (addr[2:1])
            2'd0: switches = {coin_input, ~joystick1[7], joystick1[7], start_button[0],
                              service, dip_test, 1'b1};
            2'd1: switches = 8'hff;
            2'd2: switches = dipsw_a;
            default: switches = dipsw_b;
        endcase
    end

    always_comb begin
        adc_dout = 8'hff;
        if (adc_ch == ch_motor) begin
            adc_dout = motor_pos[15:8];
        end else if (ctrl == ctrl_analog_stick) begin
            case (adc_ch)
                ch_wheel: adc_dout = ana1[7:0] ^ 8'h80;   // Offset binary
                ch_gas:   adc_dout = ana1b[15] ? ~{ana1b[14:8], ana1b[14]} : 8'h00;
                ch_brake: adc_dout = ana1b[15] ? 8'h00 : {ana1b[14:8], ana1b[14]};
                default:  ;
            endcase
        end else if (ctrl == ctrl_joystick) begin
            case (adc_ch)
                ch_wheel: adc_dout = !joystick1[0] ? 8'he0 :
                                     !joystick1[1] ? 8'h20 : 8'h80;
                ch_gas:   adc_dout = !joystick1[5] ? 8'hff : 8'h00;
                ch_brake: adc_dout = !joystick1[6] ? 8'hff : 8'h00;
                default:  ;
            endcase
        end
    end

    always_comb begin
        case (io_sel)
            sel_ppi:    io_dout = ppi_dout;
            sel_inputs: io_dout = switches;
            sel_adc:    io_dout = adc_dout;
            default:    io_dout = 8'hff;
        endcase
    end

    ppi_8255 u_ppi (
        .clk        (clk),
        .rst        (rst),
        .sel        (ppi_sel),
        .wr         (ppi_wr),
        .port_addr  (addr[2:1]),
        .din        (wdata[7:0]),
        .porta_din  ({2'b00, motor_lim, 3'b111}),  // Motor limit switches
        .dout       (ppi_dout),
        .portb_dout (portb),
        .portc_dout (portc)
    );

    motor_model #(
        .MOTOR_SHIFT (MOTOR_SHIFT)
    ) u_motor (
        .clk    (clk),
        .rst    (rst),
        .vint   (vint),
        .ctrl   (portb),
        .pos    (motor_pos),
        .limpos (motor_lim)
    );

    // The strobe needs the select held from the previous cycle
    assert property (@(posedge clk) disable iff (rst)
        obj_toggle |-> ack && $past(io_cs));

endmodule

/* rtl/motor_model.sv */
`timescale 1ns/100ps

module motor_model import outrun_pkg::*; #(
    parameter int MOTOR_SHIFT = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        vint,
    input  logic [7:0]  ctrl,     // Signed velocity
    output logic [15:0] pos,
    output logic [2:0]  limpos
);

    logic               vint_l;
    logic signed [23:0] step;
    logic signed [23:0] sum;
    logic [15:0]        pos_next;

    always_comb begin
        step = {{16{ctrl[7]}}, ctrl};
        step = step <<< MOTOR_SHIFT;
        sum  = $signed({8'd0, pos}) + step;
        if (sum < $signed({8'd0, MOTOR_MIN})) begin
            pos_next = MOTOR_MIN;
        end else if (sum > $signed({8'd0, MOTOR_MAX})) begin
            pos_next = MOTOR_MAX;
        end else begin
            pos_next = sum[15:0];
        end
    end

    // One step per frame
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vint_l <= 1'b0;
            pos    <= MOTOR_HOME;
        end else begin
            vint_l <= vint;
            if (vint && !vint_l) pos <= pos_next;
        end
    end

    assign limpos = {pos == MOTOR_MIN, pos[15:12] == 4'h8, pos == MOTOR_MAX};

    assert property (@(posedge clk) disable iff (rst)
        pos >= MOTOR_MIN && pos <= MOTOR_MAX);

endmodule

/* rtl/ppi_8255.sv */
`timescale 1ns/100ps

module ppi_8255 (
    input  logic       clk,
    input  logic       rst,
    input  logic       sel,
    input  logic       wr,
    input  logic [1:0] port_addr,
    input  logic [7:0] din,
    input  logic [7:0] porta_din,
    output logic [7:0] dout,
    output logic [7:0] portb_dout,
    output logic [7:0] portc_dout
);

    logic porta_in;   // Port A direction, high for input

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            porta_in   <= 1'b1;
            portb_dout <= 8'hff;
            portc_dout <= 8'h21;   // Video on, sound out of reset
        end else if (sel && wr) begin
            case (port_addr)
                2'd1: portb_dout <= din;
                2'd2: portc_dout <= din;
                2'd3: begin
                    if (din[7]) begin
                        // Mode set, only mode 0 is built
                        porta_in <= din[4];
                    end else begin
                        portc_dout[din[3:1]] <= din[0];   // Port C bit set/reset
                    end
                end
                default: ;
            endcase
        end
    end

    // Port A has no output latch here
    always_comb begin
        dout = 8'hff;
        if (sel) begin
            case (port_addr)
                2'd0:    dout = porta_in ? porta_din : 8'hff;
                2'd1:    dout = portb_dout;
                2'd2:    dout = portc_dout;
                default: dout = 8'hff;     // Control word is write only
            endcase
        end
    end

endmodule

/* rtl/outrun_pkg.sv */
package outrun_pkg;

    // Bus geometry
    localparam int ADDR_W     = 23;   // Word address, bits 23:1
    localparam int DATA_W     = 16;
    localparam int MEM_ADDR_W = 19;   // Address seen by the external memories

    // Work RAM page inside the mem region, address bits 18:17
    localparam logic [1:0] RAM_PAGE = 2'd3;

    // Steering motor position range
    localparam logic [15:0] MOTOR_HOME = 16'h8000;
    localparam logic [15:0] MOTOR_MIN  = 16'h2000;
    localparam logic [15:0] MOTOR_MAX  = 16'he000;

    // Bus region from address bits 23:21
    typedef enum logic [2:0] {
        reg_mem  = 3'd0,
        reg_scr  = 3'd1,
        reg_pal  = 3'd2,
        reg_obj  = 3'd3,
        reg_io   = 3'd4,
        reg_none = 3'd7
    } region_e;

    // I/O sub-range from address bits 6:4
    typedef enum logic [2:0] {
        sel_ppi        = 3'd0,
        sel_inputs     = 3'd1,
        sel_adc        = 3'd3,
        sel_none       = 3'd6,
        sel_obj_toggle = 3'd7
    } io_sel_e;

    // ADC mux channel, PPI port C bits 4:2
    typedef enum logic [2:0] {
        ch_wheel = 3'd0,
        ch_gas   = 3'd1,
        ch_brake = 3'd2,
        ch_motor = 3'd3
    } adc_ch_e;

    typedef enum logic [3:0] {
        ctrl_analog_stick = 4'd0,
        ctrl_joystick     = 4'd3
    } ctrl_type_e;

endpackage
